// File: common/mm_pkg.sv
package mm_pkg;

    // ############################################################
    // matrix geometry.
    // ############################################################
    localparam int X_ROWS        = 3;
    localparam int X_COLS_Y_ROWS = 4;
    localparam int Y_COLS        = 3;

    localparam int X_DEPTH = X_ROWS * X_COLS_Y_ROWS;
    localparam int Y_DEPTH = X_COLS_Y_ROWS * Y_COLS;
    localparam int Z_DEPTH = X_ROWS * Y_COLS;

    localparam int OP_WIDTH       = 8;
    localparam int ACC_WIDTH      = 32;
    localparam int MEM_ADDR_WIDTH = 4;

    // ############################################################
    // host port and register map.
    // ############################################################
    localparam int AXI_ADDR_WIDTH = 12;
    localparam int AXI_DATA_WIDTH = 32;

    localparam logic [AXI_ADDR_WIDTH-1:0] CTRL_ADDR   = 12'h000;
    localparam logic [AXI_ADDR_WIDTH-1:0] STATUS_ADDR = 12'h004;
    localparam logic [AXI_ADDR_WIDTH-1:0] X_BASE      = 12'h100;
    localparam logic [AXI_ADDR_WIDTH-1:0] Y_BASE      = 12'h200;
    localparam logic [AXI_ADDR_WIDTH-1:0] Z_BASE      = 12'h300;

    // loop level the core is working in.
    typedef enum logic [2:0] {
        DONE,
        X_ROW_LOOP,
        Y_COL_LOOP,
        K_LOOP,
        FETCH,
        MULTI_LOOP,
        ACCUM,
        STORE
    } mm_state_t;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

// File: rtl/operand_ram.sv
module operand_ram #(
    parameter int DEPTH      = 16,
    parameter int WIDTH      = 8,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  wen,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [WIDTH-1:0]      wdata,
    input  logic [ADDR_WIDTH-1:0] raddr,
    output logic [WIDTH-1:0]      rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wen) begin
            mem[waddr] <= wdata;
        end
        // a write to the address being read shows up at once.
        if (wen && waddr == raddr) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: rtl/mm_axil_regs.sv
module mm_axil_regs (
    input  logic                               clk,
    input  logic                               multi_iter_rst,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [mm_pkg::AXI_ADDR_WIDTH-1:0]  awaddr,
    input  logic                               wvalid,
    output logic                               wready,
    input  logic [mm_pkg::AXI_DATA_WIDTH-1:0]  wdata,
    output logic                               bvalid,
    input  logic                               bready,
    output mm_pkg::axi_resp_t                  bresp,
    input  logic                               arvalid,
    output logic                               arready,
    input  logic [mm_pkg::AXI_ADDR_WIDTH-1:0]  araddr,
    output logic                               rvalid,
    input  logic                               rready,
    output logic [mm_pkg::AXI_DATA_WIDTH-1:0]  rdata,
    output mm_pkg::axi_resp_t                  rresp,
    output logic                               start,
    input  logic                               busy,
    output logic                               x_wen,
    output logic [mm_pkg::MEM_ADDR_WIDTH-1:0]  x_waddr,
    output logic [mm_pkg::OP_WIDTH-1:0]        x_wdata,
    output logic                               y_wen,
    output logic [mm_pkg::MEM_ADDR_WIDTH-1:0]  y_waddr,
    output logic [mm_pkg::OP_WIDTH-1:0]        y_wdata,
    output logic [mm_pkg::MEM_ADDR_WIDTH-1:0]  z_raddr,
    input  logic [mm_pkg::ACC_WIDTH-1:0]       z_rdata
);
    import mm_pkg::*;

    logic want_w;
    logic want_r;
    logic grant_w;
    logic grant_r;
    logic prefer_rd;
    logic rd_pend;
    logic rd_z;
    logic busy_q;
    logic done;
    logic aw_ctrl;
    logic aw_x;
    logic aw_y;
    logic ar_z;

    logic [AXI_ADDR_WIDTH-1:0] rd_addr;
    logic [AXI_DATA_WIDTH-1:0] rd_word;
    logic [AXI_DATA_WIDTH-1:0] rd_word_q;

    axi_resp_t w_resp;
    axi_resp_t r_resp;

    function automatic logic in_window(input logic [AXI_ADDR_WIDTH-1:0] addr,
                                       input logic [AXI_ADDR_WIDTH-1:0] base,
                                       input int unsigned depth);
        return (addr[1:0] == 2'b00) && (addr >= base) &&
               (addr < base + AXI_ADDR_WIDTH'(4 * depth));
    endfunction

    // ############################################################
    // handshakes, one transaction per direction, alternating.
    // ############################################################
    assign want_w  = awvalid && wvalid && !bvalid;
    assign want_r  = arvalid && !rd_pend && !rvalid;
    assign grant_w = want_w && (!want_r || !prefer_rd);
    assign grant_r = want_r && (!want_w || prefer_rd);

    assign awready = grant_w;
    assign wready  = grant_w;
    assign arready = grant_r;

    // write decode.
    assign aw_ctrl = (awaddr == CTRL_ADDR);
    assign aw_x    = in_window(awaddr, X_BASE, X_DEPTH);
    assign aw_y    = in_window(awaddr, Y_BASE, Y_DEPTH);

    always_comb begin
        if (aw_ctrl || ((aw_x || aw_y) && !busy)) begin
            w_resp = OKAY;
        end else begin
            w_resp = SLVERR;
        end
    end

    assign start   = grant_w && aw_ctrl && wdata[0];
    assign x_wen   = grant_w && aw_x && !busy;
    assign x_waddr = awaddr[2 +: MEM_ADDR_WIDTH];
    assign x_wdata = wdata[OP_WIDTH-1:0];
    assign y_wen   = grant_w && aw_y && !busy;
    assign y_waddr = awaddr[2 +: MEM_ADDR_WIDTH];
    assign y_wdata = wdata[OP_WIDTH-1:0];

    // read decode, sampled at the address handshake.
    assign ar_z = in_window(araddr, Z_BASE, Z_DEPTH);

    always_comb begin
        r_resp  = SLVERR;
        rd_word = '0;
        if (araddr == CTRL_ADDR) begin
            r_resp = OKAY;
        end else if (araddr == STATUS_ADDR) begin
            r_resp  = OKAY;
            rd_word = {{(AXI_DATA_WIDTH - 2){1'b0}}, done, busy};
        end else if (ar_z && !busy) begin
            r_resp = OKAY;
        end
    end

    always_ff @(posedge clk or posedge multi_iter_rst) begin
        if (multi_iter_rst) begin
            bvalid    <= 1'b0;
            bresp     <= OKAY;
            rvalid    <= 1'b0;
            rresp     <= OKAY;
            rd_pend   <= 1'b0;
            rd_z      <= 1'b0;
            prefer_rd <= 1'b0;
            busy_q    <= 1'b0;
            done      <= 1'b0;
        end else begin
            busy_q <= busy;
            if (start) begin
                done <= 1'b0;
            end else if (busy_q && !busy) begin
                done <= 1'b1;
            end

            if (grant_w) begin
                bvalid    <= 1'b1;
                bresp     <= w_resp;
                prefer_rd <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (grant_r) begin
                rd_pend   <= 1'b1;
                rresp     <= r_resp;
                rd_z      <= ar_z && !busy;
                prefer_rd <= 1'b0;
            end

            // one cycle for the registered Z read.
            if (rd_pend) begin
                rd_pend <= 1'b0;
                rvalid  <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant_r) begin
            rd_addr   <= araddr;
            rd_word_q <= rd_word;
        end
    end

    assign z_raddr = rd_addr[2 +: MEM_ADDR_WIDTH];
    assign rdata   = rd_z ? z_rdata : rd_word_q;

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (multi_iter_rst) bvalid && !bready |=> bvalid
    );

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (multi_iter_rst) rvalid && !rready |=> rvalid
    );

endmodule

// File: matrix_multiplier/matrix_multiplier.sv
module matrix_multiplier (
    input  logic                               clk,
    input  logic                               multi_iter_rst,
    input  logic                               start,
    input  logic [mm_pkg::OP_WIDTH-1:0]        x_data,
    input  logic [mm_pkg::OP_WIDTH-1:0]        y_data,
    output logic [mm_pkg::MEM_ADDR_WIDTH-1:0]  x_addr,
    output logic [mm_pkg::MEM_ADDR_WIDTH-1:0]  y_addr,
    output logic [mm_pkg::MEM_ADDR_WIDTH-1:0]  z_addr,
    output logic [mm_pkg::ACC_WIDTH-1:0]       z_data,
    output logic                               z_wen,
    output logic                               busy
);
    import mm_pkg::*;

    mm_state_t state;

    // loop counters.
    logic [MEM_ADDR_WIDTH-1:0] row;
    logic [MEM_ADDR_WIDTH-1:0] col;
    logic [MEM_ADDR_WIDTH-1:0] k;
    logic [MEM_ADDR_WIDTH-1:0] x_base;
    logic [OP_WIDTH-1:0]       multi_iter;

    logic [ACC_WIDTH-1:0] product;
    logic [ACC_WIDTH-1:0] z_sum;

    assign z_wen  = (state == STORE);
    assign z_data = z_sum;

    // ############################################################
    // loop-nest state machine and address counters.
    // ############################################################
    always_ff @(posedge clk or posedge multi_iter_rst) begin
        if (multi_iter_rst) begin
            state      <= DONE;
            busy       <= 1'b0;
            row        <= '0;
            col        <= '0;
            k          <= '0;
            x_base     <= '0;
            multi_iter <= '0;
            x_addr     <= '0;
            y_addr     <= '0;
            z_addr     <= '0;
        end else begin
            case (state)
                DONE: begin
                    if (start) begin
                        busy   <= 1'b1;
                        row    <= '0;
                        col    <= '0;
                        k      <= '0;
                        x_base <= '0;
                        x_addr <= '0;
                        y_addr <= '0;
                        z_addr <= '0;
                        state  <= X_ROW_LOOP;
                    end
                end
                // first fetch of a row, or the closing cycle after the last row.
                X_ROW_LOOP: begin
                    if (row == MEM_ADDR_WIDTH'(X_ROWS)) begin
                        busy  <= 1'b0;
                        state <= DONE;
                    end else begin
                        state <= K_LOOP;
                    end
                end
                Y_COL_LOOP, FETCH: begin
                    state <= K_LOOP;
                end
                // operands are valid here.
                K_LOOP: begin
                    multi_iter <= '0;
                    if (x_data == '0) begin
                        state <= ACCUM;
                    end else begin
                        state <= MULTI_LOOP;
                    end
                end
                MULTI_LOOP: begin
                    multi_iter <= multi_iter + 1'b1;
                    if (multi_iter + OP_WIDTH'(1) == x_data) begin
                        state <= ACCUM;
                    end
                end
                ACCUM: begin
                    if (k == MEM_ADDR_WIDTH'(X_COLS_Y_ROWS - 1)) begin
                        state <= STORE;
                    end else begin
                        k      <= k + 1'b1;
                        x_addr <= x_addr + 1'b1;
                        y_addr <= y_addr + MEM_ADDR_WIDTH'(Y_COLS);
                        state  <= FETCH;
                    end
                end
                STORE: begin
                    k      <= '0;
                    z_addr <= z_addr + 1'b1;
                    if (col == MEM_ADDR_WIDTH'(Y_COLS - 1)) begin
                        col    <= '0;
                        row    <= row + 1'b1;
                        x_base <= x_base + MEM_ADDR_WIDTH'(X_COLS_Y_ROWS);
                        x_addr <= x_base + MEM_ADDR_WIDTH'(X_COLS_Y_ROWS);
                        y_addr <= '0;
                        state  <= X_ROW_LOOP;
                    end else begin
                        col    <= col + 1'b1;
                        x_addr <= x_base;
                        y_addr <= col + 1'b1;
                        state  <= Y_COL_LOOP;
                    end
                end
                default: begin
                    state <= DONE;
                end
            endcase
        end
    end

    // ############################################################
    // iterated-addition multiply and dot-product sum.
    // ############################################################
    always_ff @(posedge clk) begin
        case (state)
            K_LOOP: begin
                product <= '0;
            end
            MULTI_LOOP: begin
                product <= product + ACC_WIDTH'(y_data);
            end
            ACCUM: begin
                z_sum <= z_sum + product;
            end
            DONE, STORE: begin
                z_sum <= '0;
            end
            default: begin
            end
        endcase
    end

    a_store_while_busy: assert property (
        @(posedge clk) disable iff (multi_iter_rst) z_wen |-> busy
    );

    // busy only drops together with the return to DONE.
    a_busy_until_done: assert property (
        @(posedge clk) disable iff (multi_iter_rst) busy |=> busy || state == DONE
    );

endmodule

// File: rtl/mm_top.sv
module mm_top (
    input  logic                               clk,
    input  logic                               multi_iter_rst,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic [mm_pkg::AXI_ADDR_WIDTH-1:0]  awaddr,
    input  logic                               wvalid,
    output logic                               wready,
    input  logic [mm_pkg::AXI_DATA_WIDTH-1:0]  wdata,
    output logic                               bvalid,
    input  logic                               bready,
    output mm_pkg::axi_resp_t                  bresp,
    input  logic                               arvalid,
    output logic                               arready,
    input  logic [mm_pkg::AXI_ADDR_WIDTH-1:0]  araddr,
    output logic                               rvalid,
    input  logic                               rready,
    output logic [mm_pkg::AXI_DATA_WIDTH-1:0]  rdata,
    output mm_pkg::axi_resp_t                  rresp
);
    import mm_pkg::*;

    logic start;
    logic busy;

    // host side of the memories.
    logic                      x_wen;
    logic [MEM_ADDR_WIDTH-1:0] x_waddr;
    logic [OP_WIDTH-1:0]       x_wdata;
    logic                      y_wen;
    logic [MEM_ADDR_WIDTH-1:0] y_waddr;
    logic [OP_WIDTH-1:0]       y_wdata;
    logic [MEM_ADDR_WIDTH-1:0] z_raddr;
    logic [ACC_WIDTH-1:0]      z_rdata;

    // core side of the memories.
    logic [MEM_ADDR_WIDTH-1:0] x_addr;
    logic [OP_WIDTH-1:0]       x_data;
    logic [MEM_ADDR_WIDTH-1:0] y_addr;
    logic [OP_WIDTH-1:0]       y_data;
    logic [MEM_ADDR_WIDTH-1:0] z_addr;
    logic [ACC_WIDTH-1:0]      z_data;
    logic                      z_wen;

    mm_axil_regs mm_axil_regs_inst (
        .clk            (clk),
        .multi_iter_rst (multi_iter_rst),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .bvalid         (bvalid),
        .bready         (bready),
        .bresp          (bresp),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .start          (start),
        .busy           (busy),
        .x_wen          (x_wen),
        .x_waddr        (x_waddr),
        .x_wdata        (x_wdata),
        .y_wen          (y_wen),
        .y_waddr        (y_waddr),
        .y_wdata        (y_wdata),
        .z_raddr        (z_raddr),
        .z_rdata        (z_rdata)
    );

    operand_ram #(
        .DEPTH      (X_DEPTH),
        .WIDTH      (OP_WIDTH),
        .ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) x_ram (
        .clk   (clk),
        .wen   (x_wen),
        .waddr (x_waddr),
        .wdata (x_wdata),
        .raddr (x_addr),
        .rdata (x_data)
    );

    operand_ram #(
        .DEPTH      (Y_DEPTH),
        .WIDTH      (OP_WIDTH),
        .ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) y_ram (
        .clk   (clk),
        .wen   (y_wen),
        .waddr (y_waddr),
        .wdata (y_wdata),
        .raddr (y_addr),
        .rdata (y_data)
    );

    operand_ram #(
        .DEPTH      (Z_DEPTH),
        .WIDTH      (ACC_WIDTH),
        .ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) z_ram (
        .clk   (clk),
        .wen   (z_wen),
        .waddr (z_addr),
        .wdata (z_data),
        .raddr (z_raddr),
        .rdata (z_rdata)
    );

    matrix_multiplier matrix_multiplier_inst (
        .clk            (clk),
        .multi_iter_rst (multi_iter_rst),
        .start          (start),
        .x_data         (x_data),
        .y_data         (y_data),
        .x_addr         (x_addr),
        .y_addr         (y_addr),
        .z_addr         (z_addr),
        .z_data         (z_data),
        .z_wen          (z_wen),
        .busy           (busy)
    );

endmodule

// File: bench/mm_checker.sv
module mm_checker (
    input  logic                              clk,
    input  logic                              bvalid,
    input  logic                              bready,
    input  logic [1:0]                        bresp,
    input  logic                              rvalid,
    input  logic                              rready,
    input  logic [mm_pkg::AXI_DATA_WIDTH-1:0] rdata,
    input  logic [1:0]                        rresp,
    output logic                              finished,
    output logic [31:0]                       error_count
);
    import mm_pkg::*;

    localparam string STIM_FILE = "bench/mm_stim.txt";

    logic [127:0] test_name;
    logic         test_open;
    int           test_checks;
    int           test_errors;
    int           tests_passed;
    int           tests_with_errors;

    function automatic logic token_is(input logic [127:0] tok, input logic [7:0] ch);
        return tok == {120'd0, ch};
    endfunction

    task automatic wait_write_resp;
        @(posedge clk);
        while (!(bvalid && bready)) @(posedge clk);
    endtask

    task automatic wait_read_resp;
        @(posedge clk);
        while (!(rvalid && rready)) @(posedge clk);
    endtask

    task automatic check_value(input string what, input logic [AXI_ADDR_WIDTH-1:0] addr,
                               input logic [31:0] expected, input logic [31:0] actual);
        test_checks = test_checks + 1;
        if (expected !== actual) begin
            $display("ERROR: test %0s %0s at 0x%03h: expected 0x%0h, actual 0x%0h",
                     test_name, what, addr, expected, actual);
            test_errors = test_errors + 1;
            error_count = error_count + 1;
        end
    endtask

    task automatic close_test;
        if (test_open) begin
            if (test_errors == 0) begin
                $display("test %0s: pass, %0d checks", test_name, test_checks);
                tests_passed = tests_passed + 1;
            end else begin
                $display("test %0s: %0d of %0d checks wrong", test_name, test_errors,
                         test_checks);
                tests_with_errors = tests_with_errors + 1;
            end
        end
        test_open = 1'b0;
    endtask

    // ############################################################
    // expected responses, taken in the same order as the driver.
    // ############################################################
    initial begin
        int                        fd;
        int                        code;
        logic [127:0]              tok;
        logic [8*128-1:0]          line;
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [31:0]               data;
        logic [1:0]                resp;
        finished          = 1'b0;
        error_count       = 0;
        test_name         = '0;
        test_open         = 1'b0;
        test_checks       = 0;
        test_errors       = 0;
        tests_passed      = 0;
        tests_with_errors = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("checker cannot open %0s", STIM_FILE);
            error_count = 1;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    break;
                end
                if (token_is(tok, "#")) begin
                    code = $fgets(line, fd);
                end else if (token_is(tok, "T")) begin
                    close_test();
                    code        = $fscanf(fd, "%s", test_name);
                    test_open   = 1'b1;
                    test_checks = 0;
                    test_errors = 0;
                end else if (token_is(tok, "W")) begin
                    code = $fscanf(fd, "%h %h %h", addr, data, resp);
                    wait_write_resp();
                    check_value("write resp", addr, {30'd0, resp}, {30'd0, bresp});
                end else if (token_is(tok, "R")) begin
                    code = $fscanf(fd, "%h %h %h", addr, data, resp);
                    wait_read_resp();
                    check_value("read data", addr, data, rdata);
                    check_value("read resp", addr, {30'd0, resp}, {30'd0, rresp});
                end else if (token_is(tok, "P")) begin
                    wait_read_resp();
                    check_value("poll resp", STATUS_ADDR, 32'd0, {30'd0, rresp});
                    while (!rdata[1]) begin
                        wait_read_resp();
                        check_value("poll resp", STATUS_ADDR, 32'd0, {30'd0, rresp});
                    end
                end
            end
            $fclose(fd);
            close_test();
            if (tests_passed + tests_with_errors == 0) begin
                $display("no tests were found in %0s", STIM_FILE);
                error_count = error_count + 1;
            end
        end
        $display("summary: %0d tests passed, %0d tests with errors, %0d wrong values",
                 tests_passed, tests_with_errors, error_count);
        finished = 1'b1;
    end

endmodule

// File: bench/mm_tb.sv
module mm_tb;
    import mm_pkg::*;

    localparam string STIM_FILE     = "bench/mm_stim.txt";
    localparam int    OP_CYCLES     = 20;
    localparam int    MARGIN_CYCLES = 2000;

    logic                      clk;
    logic                      multi_iter_rst;
    logic                      awvalid;
    logic                      awready;
    logic [AXI_ADDR_WIDTH-1:0] awaddr;
    logic                      wvalid;
    logic                      wready;
    logic [AXI_DATA_WIDTH-1:0] wdata;
    logic                      bvalid;
    logic                      bready;
    axi_resp_t                 bresp;
    logic                      arvalid;
    logic                      arready;
    logic [AXI_ADDR_WIDTH-1:0] araddr;
    logic                      rvalid;
    logic                      rready;
    logic [AXI_DATA_WIDTH-1:0] rdata;
    axi_resp_t                 rresp;

    logic        checks_done;
    logic [31:0] error_count;

    int cycle_count = 0;
    int cycle_limit = 0;

    mm_top mm_top_inst (
        .clk            (clk),
        .multi_iter_rst (multi_iter_rst),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .bvalid         (bvalid),
        .bready         (bready),
        .bresp          (bresp),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp)
    );

    mm_checker mm_checker_inst (
        .clk         (clk),
        .bvalid      (bvalid),
        .bready      (bready),
        .bresp       (bresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .rresp       (rresp),
        .finished    (checks_done),
        .error_count (error_count)
    );

    always #5 clk = ~clk;

    // ############################################################
    // run length guard.
    // ############################################################
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("simulation hung: no completion within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic token_is(input logic [127:0] tok, input logic [7:0] ch);
        return tok == {120'd0, ch};
    endfunction

    // counts operations and runs so the cycle limit follows the file.
    task automatic count_ops(output int ops, output int runs, output logic found);
        int                 fd;
        int                 code;
        logic [127:0]       tok;
        logic [8*128-1:0]   line;
        ops   = 0;
        runs  = 0;
        fd    = $fopen(STIM_FILE, "r");
        found = (fd != 0);
        if (found) begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code != 1) begin
                    break;
                end
                if (token_is(tok, "#")) begin
                    code = $fgets(line, fd);
                end else if (token_is(tok, "W") || token_is(tok, "R") || token_is(tok, "T")) begin
                    ops = ops + 1;
                end else if (token_is(tok, "P")) begin
                    ops  = ops + 1;
                    runs = runs + 1;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic write_word(input logic [AXI_ADDR_WIDTH-1:0] addr,
                              input logic [AXI_DATA_WIDTH-1:0] data);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // address and data are taken together on one edge.
        @(posedge clk);
        while (!(awready && wready)) @(posedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
    endtask

    task automatic read_word(input logic [AXI_ADDR_WIDTH-1:0] addr,
                             output logic [AXI_DATA_WIDTH-1:0] data);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        data = rdata;
    endtask

    // ############################################################
    // stimulus driver.
    // ############################################################
    task automatic run_stimulus;
        int                        fd;
        int                        code;
        logic [127:0]              tok;
        logic [8*128-1:0]          line;
        logic [AXI_ADDR_WIDTH-1:0] addr;
        logic [AXI_DATA_WIDTH-1:0] data;
        logic [1:0]                resp;
        logic [AXI_DATA_WIDTH-1:0] status;
        fd = $fopen(STIM_FILE, "r");
        while (fd != 0 && !$feof(fd)) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                break;
            end
            if (token_is(tok, "#")) begin
                code = $fgets(line, fd);
            end else if (token_is(tok, "T")) begin
                code = $fscanf(fd, "%s", tok);
            end else if (token_is(tok, "W")) begin
                code = $fscanf(fd, "%h %h %h", addr, data, resp);
                write_word(addr, data);
            end else if (token_is(tok, "R")) begin
                code = $fscanf(fd, "%h %h %h", addr, data, resp);
                read_word(addr, status);
            end else if (token_is(tok, "P")) begin
                // poll until the sticky done bit shows.
                status = '0;
                while (!status[1]) begin
                    read_word(STATUS_ADDR, status);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    initial begin
        int   ops;
        int   runs;
        logic found;
        clk            = 1'b0;
        multi_iter_rst = 1'b1;
        awvalid        = 1'b0;
        awaddr         = '0;
        wvalid         = 1'b0;
        wdata          = '0;
        bready         = 1'b1;
        arvalid        = 1'b0;
        araddr         = '0;
        rready         = 1'b1;
        count_ops(ops, runs, found);
        if (!found) begin
            $display("stimulus file %0s could not be opened", STIM_FILE);
            $display("Test failed");
            $finish;
        end else begin
            cycle_limit = ops * OP_CYCLES + runs * Z_DEPTH * X_COLS_Y_ROWS * (3 + 255) +
                          MARGIN_CYCLES;
            repeat (3) @(posedge clk);
            @(negedge clk);
            multi_iter_rst = 1'b0;
            run_stimulus();
            wait (checks_done);
            if (error_count == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule

// File: bench/mm_stim.txt
# ops: W addr data resp, R addr data resp, P polls until done, T name starts a test
# fields in hex; resp 0 is OKAY and 2 is SLVERR; ops are read as one stream
T reset
R 004 0 0  R 800 0 2  R 000 0 0  W 004 1 2  W 300 5 2
T small
W 100 1 0  W 104 2 0  W 108 3 0  W 10c 4 0  W 110 5 0  W 114 6 0
W 118 7 0  W 11c 8 0  W 120 9 0  W 124 a 0  W 128 b 0  W 12c c 0
W 200 1 0  W 204 2 0  W 208 3 0  W 20c 4 0  W 210 5 0  W 214 6 0
W 218 7 0  W 21c 8 0  W 220 9 0  W 224 a 0  W 228 b 0  W 22c c 0
W 000 1 0  P
R 300 46 0  R 304 50 0  R 308 5a 0  R 30c 9e 0  R 310 b8 0
R 314 d2 0  R 318 f6 0  R 31c 120 0  R 320 14a 0
T edge
W 100 ff 0  W 104 0 0  W 108 ff 0  W 10c 0 0  W 110 ff 0  W 114 ff 0
W 118 ff 0  W 11c ff 0  W 120 0 0  W 124 0 0  W 128 0 0  W 12c 0 0
W 200 ff 0  W 204 ff 0  W 208 ff 0  W 20c ff 0  W 210 ff 0  W 214 ff 0
W 218 ff 0  W 21c ff 0  W 220 ff 0  W 224 ff 0  W 228 ff 0  W 22c ff 0
W 000 1 0  P
R 300 1fc02 0  R 304 1fc02 0  R 308 1fc02 0  R 30c 3f804 0  R 310 3f804 0
R 314 3f804 0  R 318 0 0  R 31c 0 0  R 320 0 0
T guard
W 000 1 0  W 104 7 2  R 300 0 2  P
R 300 1fc02 0  R 304 1fc02 0  R 308 1fc02 0  R 30c 3f804 0  R 310 3f804 0
R 314 3f804 0  R 318 0 0  R 31c 0 0  R 320 0 0
T rerun
W 200 1 0  W 204 0 0  W 208 2 0  W 20c 3 0  W 210 1 0  W 214 0 0
W 218 2 0  W 21c 2 0  W 220 2 0  W 224 0 0  W 228 5 0  W 22c 1 0
W 000 1 0  R 004 1 0  W 000 1 0  P  R 004 2 0
R 300 2fd 0  R 304 1fe 0  R 308 3fc 0  R 30c 5fa 0  R 310 7f8 0
R 314 4fb 0  R 318 0 0  R 31c 0 0  R 320 0 0

// File: build.f
common/mm_pkg.sv
rtl/operand_ram.sv
rtl/mm_axil_regs.sv
matrix_multiplier/matrix_multiplier.sv
rtl/mm_top.sv
bench/mm_checker.sv
bench/mm_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module mm_tb \
    --Mdir obj_dir -o mm_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/mm_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$SIM_LOG"; then
    exit 1
fi

exit 0
